//--- hdl/dcache_params.svh
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// ======================================================================
// Cache geometry
// ======================================================================
`define DC_XLEN      32      // Processor word
`define DC_LINE_W    128     // One cache line
`define DC_WORDS     4       // Words per line
`define DC_WAYS      4
`define DC_SETS      16      // Kept small to force evictions

// Address split as tag | index | word offset | byte offset
`define DC_OFFSET_W  2
`define DC_BYTE_W    2
`define DC_INDEX_W   4
`define DC_TAG_W     24

`endif

//--- hdl/dcache_pkg.sv
package dcache_pkg;

`include "dcache_params.svh"

    // Address fields with MSB first
    typedef struct packed {
        logic [`DC_TAG_W-1:0]    tag;
        logic [`DC_INDEX_W-1:0]  index;
        logic [`DC_OFFSET_W-1:0] offset;
        logic [`DC_BYTE_W-1:0]   byte_off;
    } addr_fields_t;

    // Same address word seen flat or split
    typedef union packed {
        logic [`DC_XLEN-1:0] word;
        addr_fields_t        f;
    } addr_u;

    typedef logic [`DC_LINE_W-1:0] line_t;
    typedef logic [1:0]            way_t;

    typedef struct packed {
        logic                  write;      // 1 = store
        logic [3:0]            byte_en;
        addr_u                 addr;
        logic [`DC_XLEN-1:0]   wdata;
    } proc_req_t;

    typedef struct packed {
        logic  write;                      // 1 = line write-back
        addr_u addr;                       // Always line aligned
        line_t data;
    } mem_req_t;

    typedef struct packed {
        logic                 hit;
        way_t                 hit_way;
        way_t                 victim_way;  // FIFO pointer of the set
        logic                 victim_dirty;
        logic [`DC_TAG_W-1:0] victim_tag;
        line_t                line;        // Hit line or else victim line
        logic                 flush_dirty;
        logic [`DC_TAG_W-1:0] flush_tag;
    } lookup_t;

    typedef struct packed {
        logic  we;
        way_t  way;
        logic  fill;                       // New line sets valid and bumps FIFO
        logic  mark_dirty;
        logic  clean;                      // Flush done with this way
        line_t line;
    } way_cmd_t;

    typedef enum logic [2:0] {
        Idle, Lookup, WriteBack, WriteBackDone, Fill, FillDone, FlushLine, FlushNext
    } ctrl_state_e;

endpackage

//--- hdl/dcache_word_merge.sv
`timescale 1ns/1ps

`include "dcache_params.svh"

module dcache_word_merge
(
    input  logic [`DC_OFFSET_W-1:0] offset_i,
    input  logic [3:0]              byte_en_i,
    input  logic [`DC_XLEN-1:0]     wdata_i,
    input  dcache_pkg::line_t       hit_line_i,
    input  dcache_pkg::line_t       fill_line_i,
    input  logic                    use_fill_i,
    output logic [`DC_XLEN-1:0]     word_o,
    output dcache_pkg::line_t       line_o
);

    dcache_pkg::line_t   src_line;
    logic [`DC_XLEN-1:0] merged_word;
    logic [6:0]          lsb;            // Bit position of the word

    // Hit path or freshly filled line
    assign src_line = use_fill_i ? fill_line_i : hit_line_i;

    // Word 0 sits in the top 32 bits
    assign lsb = 7'((`DC_WORDS - 1 - int'(offset_i)) * `DC_XLEN);

    // ==================================================================
    // Select and merge
    // ==================================================================
    always_comb
    begin
        word_o = src_line[lsb +: `DC_XLEN];
    end

    always_comb
    begin
        for (int b = 0; b < 4; b++)
        begin
            if (byte_en_i[b])
                merged_word[b*8 +: 8] = wdata_i[b*8 +: 8];  // Store byte
            else
                merged_word[b*8 +: 8] = word_o[b*8 +: 8];   // Keep old byte
        end
    end

    // Put the merged word back in place
    always_comb
    begin
        line_o                  = src_line;
        line_o[lsb +: `DC_XLEN] = merged_word;
    end

endmodule

//--- hdl/dcache_ways.sv
`timescale 1ns/1ps

`include "dcache_params.svh"

module dcache_ways
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic [`DC_INDEX_W-1:0] set_index_i,
    input  logic [`DC_TAG_W-1:0]   tag_i,
    input  dcache_pkg::way_t       flush_way_i,
    input  dcache_pkg::way_cmd_t   way_cmd_i,
    output dcache_pkg::lookup_t    lookup_o
);

    // ==================================================================
    // Storage
    // ==================================================================
    logic [`DC_TAG_W-1:0] tag_mem  [`DC_SETS][`DC_WAYS];
    dcache_pkg::line_t    data_mem [`DC_SETS][`DC_WAYS];
    logic [`DC_SETS-1:0][`DC_WAYS-1:0] valid_q;
    logic [`DC_SETS-1:0][`DC_WAYS-1:0] dirty_q;
    dcache_pkg::way_t     fifo_q   [`DC_SETS];   // Next victim per set

    logic [`DC_INDEX_W-1:0] idx_q;               // Index seen last cycle
    logic [`DC_WAYS-1:0]    way_hit;
    dcache_pkg::way_t       hit_way;
    dcache_pkg::way_t       victim;
    dcache_pkg::way_t       sel_way;

    always_ff @(posedge clk_i)
    begin
        idx_q <= set_index_i;
    end

    // ==================================================================
    // Lookup valid one cycle after the index
    // ==================================================================
    always_comb
    begin
        hit_way = '0;
        for (int w = 0; w < `DC_WAYS; w++)
        begin
            way_hit[w] = valid_q[idx_q][w] && (tag_mem[idx_q][w] == tag_i);
            if (way_hit[w])
                hit_way = dcache_pkg::way_t'(w);  // Tags unique within a set
        end
    end

    assign victim  = fifo_q[idx_q];
    assign sel_way = (|way_hit) ? hit_way : victim;

    always_comb
    begin
        lookup_o.hit          = |way_hit;
        lookup_o.hit_way      = hit_way;
        lookup_o.victim_way   = victim;
        lookup_o.victim_dirty = valid_q[idx_q][victim] && dirty_q[idx_q][victim];
        lookup_o.victim_tag   = tag_mem[idx_q][victim];
        lookup_o.line         = data_mem[idx_q][sel_way];
        lookup_o.flush_dirty  = valid_q[idx_q][flush_way_i] && dirty_q[idx_q][flush_way_i];
        lookup_o.flush_tag    = tag_mem[idx_q][flush_way_i];
    end

    // ==================================================================
    // Updates
    // ==================================================================
    always_ff @(posedge clk_i)
    begin
        if (way_cmd_i.we)
        begin
            data_mem[idx_q][way_cmd_i.way] <= way_cmd_i.line;
            if (way_cmd_i.fill)
                tag_mem[idx_q][way_cmd_i.way] <= tag_i;  // New owner of the way
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            valid_q <= '0;
            dirty_q <= '0;
            for (int s = 0; s < `DC_SETS; s++)
                fifo_q[s] <= '0;
        end
        else
        begin
            if (way_cmd_i.we && way_cmd_i.fill)
            begin
                valid_q[idx_q][way_cmd_i.way] <= 1'b1;
                dirty_q[idx_q][way_cmd_i.way] <= way_cmd_i.mark_dirty;  // Load fills clean
                fifo_q[idx_q]                 <= fifo_q[idx_q] + 1'b1;
            end
            else if (way_cmd_i.we && way_cmd_i.mark_dirty)
                dirty_q[idx_q][way_cmd_i.way] <= 1'b1;  // Store hit
            else if (way_cmd_i.clean)
                dirty_q[idx_q][way_cmd_i.way] <= 1'b0;
        end
    end

endmodule

//--- hdl/dcache_ctrl.sv
`timescale 1ns/1ps

`include "dcache_params.svh"

module dcache_ctrl
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   p_strobe_i,
    input  logic                   p_flush_i,
    input  dcache_pkg::proc_req_t  p_req_i,
    output logic [`DC_XLEN-1:0]    p_rdata_o,
    output logic                   p_ready_o,
    output logic                   busy_flushing_o,
    output dcache_pkg::mem_req_t   m_req_o,
    output logic                   m_strobe_o,
    input  dcache_pkg::line_t      m_rdata_i,
    input  logic                   m_ready_i,
    input  dcache_pkg::lookup_t    lookup_i,
    input  logic [`DC_XLEN-1:0]    sel_word_i,
    input  dcache_pkg::line_t      merged_line_i,
    output logic [`DC_INDEX_W-1:0] set_index_o,
    output dcache_pkg::way_t       flush_way_o,
    output dcache_pkg::way_cmd_t   way_cmd_o,
    output dcache_pkg::line_t      fill_line_o,
    output dcache_pkg::proc_req_t  req_o
);

    dcache_pkg::ctrl_state_e state;
    dcache_pkg::proc_req_t   req_q;
    dcache_pkg::line_t       fill_q;
    logic [`DC_INDEX_W-1:0]  flush_set;
    logic                    last_way;
    logic                    last_line;

    assign last_way    = (flush_way_o == dcache_pkg::way_t'(`DC_WAYS - 1));
    assign last_line   = last_way && (flush_set == `DC_INDEX_W'(`DC_SETS - 1));
    assign fill_line_o = fill_q;

    // During a flush the walked way's tag is compared so its line comes back selected
    always_comb
    begin
        req_o = req_q;
        if (busy_flushing_o)
            req_o.addr.f.tag = lookup_i.flush_tag;
    end

    // Index one cycle ahead of the state that uses the lookup
    always_comb
    begin
        case (state)
            dcache_pkg::Idle:      set_index_o = p_flush_i ? flush_set : p_req_i.addr.f.index;
            dcache_pkg::FlushLine: set_index_o = flush_set;
            dcache_pkg::FlushNext: set_index_o = last_way ? flush_set + 1'b1 : flush_set;
            default:               set_index_o = req_q.addr.f.index;
        endcase
    end

    // ==================================================================
    // Array writes and processor response
    // ==================================================================
    always_comb
    begin
        way_cmd_o = '0;
        case (state)
            dcache_pkg::Lookup:
            begin
                way_cmd_o.we         = lookup_i.hit && req_q.write;  // Store hit
                way_cmd_o.way        = lookup_i.hit_way;
                way_cmd_o.mark_dirty = 1'b1;
                way_cmd_o.line       = merged_line_i;
            end
            dcache_pkg::FillDone:
            begin
                way_cmd_o.we         = 1'b1;
                way_cmd_o.way        = lookup_i.victim_way;
                way_cmd_o.fill       = 1'b1;
                way_cmd_o.mark_dirty = req_q.write;
                way_cmd_o.line       = req_q.write ? merged_line_i : fill_q;
            end
            dcache_pkg::FlushLine:
            begin
                // Written back so now clean
                way_cmd_o.clean = lookup_i.flush_dirty && m_strobe_o && m_ready_i;
                way_cmd_o.way   = flush_way_o;
            end
            default:
                way_cmd_o = '0;
        endcase
    end

    assign p_ready_o = (state == dcache_pkg::Lookup && lookup_i.hit) ||
                       (state == dcache_pkg::FillDone) ||
                       (state == dcache_pkg::FlushNext && last_line);
    assign p_rdata_o = sel_word_i;      // Meaningful with p_ready_o on loads

    // ==================================================================
    // State machine
    // ==================================================================
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            state           <= dcache_pkg::Idle;
            m_strobe_o      <= 1'b0;
            busy_flushing_o <= 1'b0;
            flush_set       <= '0;
            flush_way_o     <= '0;
        end
        else
        begin
            case (state)
                dcache_pkg::Idle:
                    if (p_flush_i)
                    begin
                        busy_flushing_o <= 1'b1;
                        state           <= dcache_pkg::FlushLine;
                    end
                    else if (p_strobe_i)
                        state <= dcache_pkg::Lookup;
                dcache_pkg::Lookup:
                    if (!lookup_i.hit)
                    begin
                        m_strobe_o <= 1'b1;
                        state      <= lookup_i.victim_dirty ? dcache_pkg::WriteBack
                                                            : dcache_pkg::Fill;
                    end
                    else
                        state <= dcache_pkg::Idle;
                dcache_pkg::WriteBack:
                    if (m_ready_i)
                    begin
                        m_strobe_o <= 1'b0;
                        state      <= dcache_pkg::WriteBackDone;
                    end
                dcache_pkg::WriteBackDone:
                begin
                    m_strobe_o <= 1'b1;  // Now the fill read
                    state      <= dcache_pkg::Fill;
                end
                dcache_pkg::Fill:
                    if (m_ready_i)
                    begin
                        m_strobe_o <= 1'b0;
                        state      <= dcache_pkg::FillDone;
                    end
                dcache_pkg::FillDone:
                    state <= dcache_pkg::Idle;
                dcache_pkg::FlushLine:
                    if (!lookup_i.flush_dirty)
                        state <= dcache_pkg::FlushNext;  // Clean line is skipped
                    else if (!m_strobe_o)
                        m_strobe_o <= 1'b1;
                    else if (m_ready_i)
                    begin
                        m_strobe_o <= 1'b0;
                        state      <= dcache_pkg::FlushNext;
                    end
                dcache_pkg::FlushNext:
                begin
                    flush_way_o <= flush_way_o + 1'b1;   // Way walks fastest
                    if (last_way)
                        flush_set <= flush_set + 1'b1;
                    if (last_line)
                    begin
                        busy_flushing_o <= 1'b0;
                        state           <= dcache_pkg::Idle;
                    end
                    else
                        state <= dcache_pkg::FlushLine;
                end
                default:
                    state <= dcache_pkg::Idle;
            endcase
        end
    end

    // ==================================================================
    // Request, fill and memory payload
    // ==================================================================
    always_ff @(posedge clk_i)
    begin
        if (state == dcache_pkg::Idle && p_strobe_i)
            req_q <= p_req_i;
        if (state == dcache_pkg::Fill && m_ready_i)
            fill_q <= m_rdata_i;
        if (state == dcache_pkg::Lookup)
        begin
            // Victim write-back or else the line-aligned fill
            m_req_o.write        <= lookup_i.victim_dirty;
            m_req_o.addr.word    <= req_q.addr.word;
            m_req_o.addr.f.offset   <= '0;
            m_req_o.addr.f.byte_off <= '0;
            if (lookup_i.victim_dirty)
                m_req_o.addr.f.tag <= lookup_i.victim_tag;
            m_req_o.data <= lookup_i.line;
        end
        else if (state == dcache_pkg::WriteBackDone)
        begin
            m_req_o.write     <= 1'b0;
            m_req_o.addr.word <= {req_q.addr.word[`DC_XLEN-1:`DC_OFFSET_W+`DC_BYTE_W],
                                  {(`DC_OFFSET_W + `DC_BYTE_W){1'b0}}};
        end
        else if (state == dcache_pkg::FlushLine && !m_strobe_o)
        begin
            m_req_o.write               <= 1'b1;
            m_req_o.addr.f.tag          <= lookup_i.flush_tag;
            m_req_o.addr.f.index        <= flush_set;
            m_req_o.addr.f.offset       <= '0;
            m_req_o.addr.f.byte_off     <= '0;
            m_req_o.data                <= lookup_i.line;
        end
    end

endmodule

//--- hdl/dcache_top.sv
`timescale 1ns/1ps

`include "dcache_params.svh"

module dcache_top
(
    input  logic                  clk_i,
    input  logic                  rst_i,

    // Processor side
    input  logic                  p_strobe_i,
    input  logic                  p_flush_i,
    input  dcache_pkg::proc_req_t p_req_i,
    output logic [`DC_XLEN-1:0]   p_rdata_o,
    output logic                  p_ready_o,
    output logic                  busy_flushing_o,

    // Memory side with one full line per transfer
    output dcache_pkg::mem_req_t  m_req_o,
    output logic                  m_strobe_o,
    input  dcache_pkg::line_t     m_rdata_i,
    input  logic                  m_ready_i
);

    // ==================================================================
    // Internal links
    // ==================================================================
    logic [`DC_INDEX_W-1:0] set_index;
    dcache_pkg::way_t       flush_way;
    dcache_pkg::way_cmd_t   way_cmd;
    dcache_pkg::lookup_t    lookup;
    dcache_pkg::proc_req_t  req;          // Captured request
    dcache_pkg::line_t      fill_line;
    dcache_pkg::line_t      merged_line;
    logic [`DC_XLEN-1:0]    sel_word;

    dcache_ctrl i_dcache_ctrl (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .p_strobe_i      (p_strobe_i),
        .p_flush_i       (p_flush_i),
        .p_req_i         (p_req_i),
        .p_rdata_o       (p_rdata_o),
        .p_ready_o       (p_ready_o),
        .busy_flushing_o (busy_flushing_o),
        .m_req_o         (m_req_o),
        .m_strobe_o      (m_strobe_o),
        .m_rdata_i       (m_rdata_i),
        .m_ready_i       (m_ready_i),
        .lookup_i        (lookup),
        .sel_word_i      (sel_word),
        .merged_line_i   (merged_line),
        .set_index_o     (set_index),
        .flush_way_o     (flush_way),
        .way_cmd_o       (way_cmd),
        .fill_line_o     (fill_line),
        .req_o           (req)
    );

    dcache_ways i_dcache_ways (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .set_index_i (set_index),
        .tag_i       (req.addr.f.tag),
        .flush_way_i (flush_way),
        .way_cmd_i   (way_cmd),
        .lookup_o    (lookup)
    );

    // Fill line is used only while the fill is written
    dcache_word_merge i_dcache_word_merge (
        .offset_i    (req.addr.f.offset),
        .byte_en_i   (req.byte_en),
        .wdata_i     (req.wdata),
        .hit_line_i  (lookup.line),
        .fill_line_i (fill_line),
        .use_fill_i  (way_cmd.fill),
        .word_o      (sel_word),
        .line_o      (merged_line)
    );

endmodule

//--- bench/tb_mem_model.sv
`timescale 1ns/1ps

`include "dcache_params.svh"

module tb_mem_model
(
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  dcache_pkg::mem_req_t req_i,
    input  logic                 strobe_i,
    output dcache_pkg::line_t    rdata_o,
    output logic                 ready_o,
    output int                   reads_o,    // Line reads served
    output int                   writes_o    // Line writes served
);

    logic [`DC_XLEN-1:0] mem_q [logic [29:0]];  // Sparse and indexed by word address
    int                  seed     = 32'hbff1769c;
    dcache_pkg::line_t   rdata_q  = '0;
    logic                ready_q  = 1'b0;
    logic                busy_q   = 1'b0;      // Request seen and delay running
    int                  wait_q   = 0;
    int                  reads_q  = 0;
    int                  writes_q = 0;

    assign rdata_o  = rdata_q;
    assign ready_o  = ready_q;
    assign reads_o  = reads_q;
    assign writes_o = writes_q;

    // Untouched word holds its own byte address
    function automatic logic [`DC_XLEN-1:0] read_word(input logic [29:0] waddr);
        if (mem_q.exists(waddr))
            return mem_q[waddr];
        return {waddr, 2'b00};
    endfunction

    // Word 0 of the line in the top 32 bits
    function automatic dcache_pkg::line_t peek_line(input logic [31:0] addr);
        dcache_pkg::line_t line;
        for (int w = 0; w < `DC_WORDS; w++)
            line[(`DC_WORDS - 1 - w) * `DC_XLEN +: `DC_XLEN] = read_word({addr[31:4], 2'(w)});
        return line;
    endfunction

    task automatic write_line(input logic [31:0] addr, input dcache_pkg::line_t line);
        for (int w = 0; w < `DC_WORDS; w++)
            mem_q[{addr[31:4], 2'(w)}] = line[(`DC_WORDS - 1 - w) * `DC_XLEN +: `DC_XLEN];
    endtask

    // ==================================================================
    // Strobe until ready with a random delay of 1 to 8 cycles
    // ==================================================================
    always @(posedge clk_i)
    begin
        if (rst_i)
        begin
            ready_q <= 1'b0;
            busy_q  <= 1'b0;
            wait_q  <= 0;
        end
        else
        begin
            ready_q <= 1'b0;                          // One-cycle pulse
            if (strobe_i && !ready_q)
            begin
                if (!busy_q)
                begin
                    busy_q <= 1'b1;
                    wait_q <= {$random(seed)} % 8;
                end
                else if (wait_q == 0)
                begin
                    busy_q  <= 1'b0;
                    ready_q <= 1'b1;
                    if (req_i.write)
                    begin
                        write_line(req_i.addr.word, req_i.data);
                        writes_q <= writes_q + 1;
                    end
                    else
                    begin
                        rdata_q <= peek_line(req_i.addr.word);  // Valid with ready
                        reads_q <= reads_q + 1;
                    end
                end
                else
                    wait_q <= wait_q - 1;
            end
        end
    end

endmodule

//--- bench/tb_dcache.sv
`timescale 1ns/1ps

`include "dcache_params.svh"

module tb_dcache;

    localparam int ops_max       = 64;
    localparam int cols          = 8;    // Tokens per testdata record
    localparam int cycles_per_op = 200;
    localparam int reset_cycles  = 10;

    logic                  clk;
    logic                  rst;
    logic                  p_strobe;
    logic                  p_flush;
    dcache_pkg::proc_req_t p_req;
    logic [`DC_XLEN-1:0]   p_rdata;
    logic                  p_ready;
    logic                  busy_flushing;
    dcache_pkg::mem_req_t  m_req;
    logic                  m_strobe;
    dcache_pkg::line_t     m_rdata;
    logic                  m_ready;
    int                    mem_reads;
    int                    mem_writes;

    logic [31:0] testdata [ops_max * cols];
    int          n_ops       = 0;
    int          cycle_cnt   = 0;
    int          cycle_limit = 0;                // Zero until the file is read

    dcache_top i_dcache_top (
        .clk_i           (clk),
        .rst_i           (rst),
        .p_strobe_i      (p_strobe),
        .p_flush_i       (p_flush),
        .p_req_i         (p_req),
        .p_rdata_o       (p_rdata),
        .p_ready_o       (p_ready),
        .busy_flushing_o (busy_flushing),
        .m_req_o         (m_req),
        .m_strobe_o      (m_strobe),
        .m_rdata_i       (m_rdata),
        .m_ready_i       (m_ready)
    );

    tb_mem_model i_mem_model (
        .clk_i    (clk),
        .rst_i    (rst),
        .req_i    (m_req),
        .strobe_i (m_strobe),
        .rdata_o  (m_rdata),
        .ready_o  (m_ready),
        .reads_o  (mem_reads),
        .writes_o (mem_writes)
    );

    always #4 clk = ~clk;                      // 8 ns period

    // ==================================================================
    // Failure reporting and compare tasks
    // ==================================================================
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [`DC_XLEN-1:0] got,
                              input logic [`DC_XLEN-1:0] exp);
        if (got !== exp)
            abort_run($sformatf("Error: %s is 0x%08h, expected 0x%08h", name, got, exp));
    endtask

    task automatic check_line(input string name, input dcache_pkg::line_t got,
                              input dcache_pkg::line_t exp);
        if (got !== exp)
            abort_run($sformatf("Error: %s is 0x%032h, expected 0x%032h", name, got, exp));
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
            abort_run($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit)
            abort_run("Timeout: the cache did not finish the operations in time");
    end

    // ==================================================================
    // Processor side drivers
    // ==================================================================
    task automatic wait_ready();
        @(negedge clk);                         // Outputs settled here
        while (!p_ready)
            @(negedge clk);
    endtask

    // One request with the strobe held for a single cycle
    task automatic issue_access(input logic wr, input logic [31:0] addr,
                                input logic [3:0] be, input logic [31:0] data);
        dcache_pkg::proc_req_t req;
        req.write     = wr;
        req.byte_en   = be;
        req.addr.word = addr;
        req.wdata     = data;
        @(posedge clk);
        p_req    <= req;
        p_strobe <= 1'b1;
        @(posedge clk);
        p_strobe <= 1'b0;
        wait_ready();
    endtask

    task automatic flush_cache();
        @(posedge clk);
        p_flush <= 1'b1;
        @(posedge clk);
        p_flush <= 1'b0;
        @(negedge clk);
        if (!busy_flushing)
            abort_run("busy_flushing_o did not rise the cycle after the flush request");
        wait_ready();
        @(negedge clk);
        if (busy_flushing)
            abort_run("busy_flushing_o stayed high after the flush ended");
    endtask

    // Record layout is op addr byte_en data exp0 exp1 exp2 exp3
    task automatic run_op(input int n);
        int                base;
        logic [31:0]       addr;
        dcache_pkg::line_t exp_line;
        base     = n * cols;
        addr     = testdata[base + 1];
        exp_line = {testdata[base + 4], testdata[base + 5],
                    testdata[base + 6], testdata[base + 7]};
        case (testdata[base])
            32'd1:
            begin
                issue_access(1'b0, addr, 4'h0, 32'h0);
                check_word("p_rdata_o", p_rdata, testdata[base + 4]);
            end
            32'd2:
                issue_access(1'b1, addr, testdata[base + 2][3:0], testdata[base + 3]);
            32'd3:
                flush_cache();
            32'd4:
            begin
                check_count("memory line reads", mem_reads, int'(testdata[base + 4]));
                check_count("memory line writes", mem_writes, int'(testdata[base + 5]));
            end
            32'd5:
                check_line("memory line", i_mem_model.peek_line(addr), exp_line);
            default:
                abort_run($sformatf("Unknown operation code in testdata record %0d", n));
        endcase
    endtask

    // Records end at the first op of zero
    function automatic int count_ops();
        int n;
        n = 0;
        while (n < ops_max && testdata[n * cols] != 0)
            n++;
        return n;
    endfunction

    // ==================================================================
    // Main sequence
    // ==================================================================
    initial
    begin
        clk      = 1'b0;
        rst      = 1'b1;
        p_strobe = 1'b0;
        p_flush  = 1'b0;
        p_req    = '0;
        for (int i = 0; i < ops_max * cols; i++)
            testdata[i] = '0;
        $readmemh("bench/dcache_testdata.txt", testdata);
        n_ops = count_ops();
        if (n_ops == 0)
            abort_run("No operations found in bench/dcache_testdata.txt");
        cycle_limit = n_ops * cycles_per_op + reset_cycles;
        $display("Running %0d operations", n_ops);

        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < n_ops; i++)
            run_op(i);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- compile.f
+incdir+hdl
hdl/dcache_pkg.sv
hdl/dcache_word_merge.sv
hdl/dcache_ways.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
bench/tb_mem_model.sv
bench/tb_dcache.sv

//--- Makefile
TOP := tb_dcache

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f compile.f -o $(TOP)
	out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q '^\*\*\* PASSED \*\*\*$$'

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- bench/dcache_testdata.txt
// op addr byte_en data exp0 exp1 exp2 exp3, all hex
// op 1 read, 2 write, 3 flush, 4 counts (exp0 reads, exp1 writes), 5 memory line
1 00001000 0 00000000 00001000 0 0 0
4 0 0 0 1 0 0 0
1 00001004 0 00000000 00001004 0 0 0
4 0 0 0 1 0 0 0
2 00002010 1 AABBCCDD 0 0 0 0
1 00002010 0 00000000 000020DD 0 0 0
2 00002014 3 11223344 0 0 0 0
1 00002014 0 00000000 00003344 0 0 0
2 00002018 4 55667788 0 0 0 0
1 00002018 0 00000000 00662018 0 0 0
2 0000201C C 99AABBCC 0 0 0 0
1 0000201C 0 00000000 99AA201C 0 0 0
2 00002010 8 EE000000 0 0 0 0
1 00002010 0 00000000 EE0020DD 0 0 0
2 00002014 F CAFEF00D 0 0 0 0
1 00002014 0 00000000 CAFEF00D 0 0 0
4 0 0 0 2 0 0 0
1 00003020 0 00000000 00003020 0 0 0
1 00004020 0 00000000 00004020 0 0 0
1 00005020 0 00000000 00005020 0 0 0
1 00006020 0 00000000 00006020 0 0 0
1 00007020 0 00000000 00007020 0 0 0
4 0 0 0 7 0 0 0
1 00004020 0 00000000 00004020 0 0 0
4 0 0 0 7 0 0 0
1 00003020 0 00000000 00003020 0 0 0
4 0 0 0 8 0 0 0
2 00008030 F 12345678 0 0 0 0
1 00009030 0 00000000 00009030 0 0 0
1 0000A030 0 00000000 0000A030 0 0 0
1 0000B030 0 00000000 0000B030 0 0 0
1 0000C030 0 00000000 0000C030 0 0 0
4 0 0 0 D 1 0 0
5 00008030 0 00000000 12345678 00008034 00008038 0000803C
1 00008030 0 00000000 12345678 0 0 0
4 0 0 0 E 1 0 0
2 00001008 F DEADBEEF 0 0 0 0
2 0000D0F0 3 1234BEEF 0 0 0 0
1 0000D0F0 0 00000000 0000BEEF 0 0 0
3 0 0 0 0 0 0 0
4 0 0 0 F 4 0 0
5 00001000 0 00000000 00001000 00001004 DEADBEEF 0000100C
5 00002010 0 00000000 EE0020DD CAFEF00D 00662018 99AA201C
5 0000D0F0 0 00000000 0000BEEF 0000D0F4 0000D0F8 0000D0FC
3 0 0 0 0 0 0 0
4 0 0 0 F 4 0 0
1 00002014 0 00000000 CAFEF00D 0 0 0
4 0 0 0 F 4 0 0
0 0 0 0 0 0 0 0
